//--- common/stream_mux_pkg.sv
package stream_mux_pkg;

  // Merge geometry
  localparam int N_REGIONS = 4;           // Region streams into the merge
  localparam int ID_BITS   = 2;           // Region index carried on every output beat

  // Stream widths
  localparam int DATA_BITS = 64;
  localparam int KEEP_BITS = DATA_BITS / 8; // One keep bit per data byte

  // Queue depths
  localparam int IN_DEPTH  = 4;           // Per-region input queue
  localparam int OUT_DEPTH = 2;           // Shared output queue after the arbiter

  // One stream beat, 73 bits
  // Field order sets the packed layout: data on top, last in bit 0
  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic [KEEP_BITS-1:0] keep;
    logic                 last;           // End of packet
  } beat_t;

  // Merged beat plus the region it came from, 75 bits
  typedef struct packed {
    beat_t              beat;
    logic [ID_BITS-1:0] id;               // Source region index
  } tagged_beat_t;

endpackage

//--- hw/axis_fifo.sv
module axis_fifo #(
  parameter type payload_t = logic,       // Beat layout set per instance
  parameter int  DEPTH     = 2            // Number of entries
) (
  input  logic     aclk,
  input  logic     aresetn,

  // Write side
  input  logic     s_tvalid,
  output logic     s_tready,
  input  payload_t s_payload,

  // Read side
  output logic     m_tvalid,
  input  logic     m_tready,
  output payload_t m_payload
);

  // Pointer and count widths
  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1); // Count spans 0..DEPTH

  localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(DEPTH - 1);
  localparam logic [CNT_BITS-1:0] FULL_CNT  = CNT_BITS'(DEPTH);

  payload_t mem [DEPTH];                  // Storage ring

  logic [PTR_BITS-1:0] wr_ptr;            // Next slot to write
  logic [PTR_BITS-1:0] rd_ptr;            // Slot shown on the read side
  logic [CNT_BITS-1:0] count;             // Entries held

  logic full;
  logic wr_en;
  logic rd_en;

  assign full  = (count == FULL_CNT);
  assign wr_en = s_tvalid && s_tready;
  assign rd_en = m_tvalid && m_tready;

  // Full only blocks a write when nothing leaves in the same cycle
  assign s_tready = !full || m_tready;

  // Head entry straight out of storage
  // Valid comes from the count register, so a new beat shows one cycle after its write
  assign m_tvalid  = (count != '0);
  assign m_payload = mem[rd_ptr];

  // Write into the tail slot
  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= s_payload;           // When full this slot is the head being read
    end
  end

  // Pointers and occupancy
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;                       // Empty after reset
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1; // Wrap at DEPTH
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      end

      // Simultaneous write and read leaves the count alone
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // A stalled head beat must stay put until the sink takes it
  a_hold_stable: assert property (
    @(posedge aclk) disable iff (!aresetn)
    (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_payload))
  ) else $error("axis_fifo: head beat changed while stalled");

  // Occupancy bound across writes and reads
  a_count_bound: assert property (
    @(posedge aclk) disable iff (!aresetn)
    count <= FULL_CNT
  ) else $error("axis_fifo: count above DEPTH");

endmodule

//--- axis_arbiter/axis_arbiter.sv
module axis_arbiter #(
  parameter int N_ID = stream_mux_pkg::N_REGIONS // Regions merged, up to 2**ID_BITS
) (
  input  logic aclk,
  input  logic aresetn,

  // Sink side, one lane per region
  output logic [N_ID-1:0]                                tready_snk,
  input  logic [N_ID-1:0]                                tvalid_snk,
  input  logic [N_ID-1:0][stream_mux_pkg::DATA_BITS-1:0] tdata_snk,
  input  logic [N_ID-1:0][stream_mux_pkg::KEEP_BITS-1:0] tkeep_snk,
  input  logic [N_ID-1:0]                                tlast_snk,

  // Source side, merged stream
  input  logic                                tready_src,
  output logic                                tvalid_src,
  output logic [stream_mux_pkg::DATA_BITS-1:0] tdata_src,
  output logic [stream_mux_pkg::KEEP_BITS-1:0] tkeep_src,
  output logic                                tlast_src,
  output logic [stream_mux_pkg::ID_BITS-1:0]   id_src
);

  import stream_mux_pkg::*;

  localparam logic [ID_BITS-1:0] LAST_ID = ID_BITS'(N_ID - 1);

  logic [ID_BITS-1:0] rr_ptr;             // Search start for this cycle
  logic [ID_BITS-1:0] win_idx;            // Granted region
  logic               found;              // Some region is valid

  // Region index at offset ofs from base, wrapping at N_ID
  function automatic logic [ID_BITS-1:0] wrap_idx(
    input logic [ID_BITS-1:0] base,
    input int                 ofs
  );
    int sum;
    sum = int'(base) + ofs;
    if (sum >= N_ID) begin
      sum = sum - N_ID;
    end
    return ID_BITS'(sum);
  endfunction

  // Round-robin pointer
  // Steps on every accepted beat whichever region won, so it does not chase the winner
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rr_ptr <= '0;                       // Defined start at region 0
    end else if (tvalid_src && tready_src) begin
      rr_ptr <= (rr_ptr == LAST_ID) ? '0 : rr_ptr + 1'b1;
    end
  end

  // Search from the pointer, wrapping around, first valid lane wins
  always_comb begin
    found   = 1'b0;
    win_idx = rr_ptr;                     // Idle default, nothing routed
    for (int i = 0; i < N_ID; i++) begin
      if (!found && tvalid_snk[wrap_idx(rr_ptr, i)]) begin
        found   = 1'b1;
        win_idx = wrap_idx(rr_ptr, i);
      end
    end
  end

  // Beat mux and ready return
  always_comb begin
    tready_snk          = '0;             // Losers see ready low
    tready_snk[win_idx] = tready_src && found; // Only the winner follows the sink
    tvalid_src          = found;
    tdata_src           = tdata_snk[win_idx];
    tkeep_src           = tkeep_snk[win_idx];
    tlast_src           = tlast_snk[win_idx];
    id_src              = win_idx;        // Lets the receiver split regions again
  end

  // No more than one region may ever be popped per cycle
  a_ready_onehot: assert property (
    @(posedge aclk) disable iff (!aresetn)
    $onehot0(tready_snk)
  ) else $error("axis_arbiter: ready returned to several regions");

  // Merge never idles while any queue holds a beat
  a_valid_or: assert property (
    @(posedge aclk) disable iff (!aresetn)
    tvalid_src == (|tvalid_snk)
  ) else $error("axis_arbiter: source valid differs from OR of sink valids");

  // Pointer only ever names a real region
  a_ptr_range: assert property (
    @(posedge aclk) disable iff (!aresetn)
    int'(rr_ptr) < N_ID
  ) else $error("axis_arbiter: pointer out of range");

endmodule

//--- hw/stream_mux_top.sv
module stream_mux_top (
  input  logic aclk,
  input  logic aresetn,

  // Region streams in
  input  logic [stream_mux_pkg::N_REGIONS-1:0]                                s_tvalid,
  output logic [stream_mux_pkg::N_REGIONS-1:0]                                s_tready,
  input  logic [stream_mux_pkg::N_REGIONS-1:0][stream_mux_pkg::DATA_BITS-1:0] s_tdata,
  input  logic [stream_mux_pkg::N_REGIONS-1:0][stream_mux_pkg::KEEP_BITS-1:0] s_tkeep,
  input  logic [stream_mux_pkg::N_REGIONS-1:0]                                s_tlast,

  // Merged stream out
  output logic                                 m_tvalid,
  input  logic                                 m_tready,
  output logic [stream_mux_pkg::DATA_BITS-1:0] m_tdata,
  output logic [stream_mux_pkg::KEEP_BITS-1:0] m_tkeep,
  output logic                                 m_tlast,
  output logic [stream_mux_pkg::ID_BITS-1:0]   m_tid
);

  import stream_mux_pkg::*;

  // Region side, one beat per input queue
  beat_t in_beat [N_REGIONS];             // Packed from the ports
  beat_t q_beat  [N_REGIONS];             // Head of each input queue

  logic [N_REGIONS-1:0] q_tvalid;
  logic [N_REGIONS-1:0] q_tready;         // Grant back from the arbiter

  // Arbiter sink lanes, unpacked from queue heads
  logic [N_REGIONS-1:0][DATA_BITS-1:0] q_tdata;
  logic [N_REGIONS-1:0][KEEP_BITS-1:0] q_tkeep;
  logic [N_REGIONS-1:0]                q_tlast;

  // Merged beat between arbiter and output queue
  logic                 arb_tvalid;
  logic                 arb_tready;
  logic [DATA_BITS-1:0] arb_tdata;
  logic [KEEP_BITS-1:0] arb_tkeep;
  logic                 arb_tlast;
  logic [ID_BITS-1:0]   arb_id;

  tagged_beat_t arb_beat;                 // Into the output queue
  tagged_beat_t out_beat;                 // Head of the output queue

  // One input queue per region
  for (genvar r = 0; r < N_REGIONS; r++) begin : g_region
    assign in_beat[r] = '{data: s_tdata[r], keep: s_tkeep[r], last: s_tlast[r]};

    axis_fifo #(
      .payload_t (beat_t),
      .DEPTH     (IN_DEPTH)
    ) u_in_fifo (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .s_tvalid  (s_tvalid[r]),
      .s_tready  (s_tready[r]),
      .s_payload (in_beat[r]),
      .m_tvalid  (q_tvalid[r]),
      .m_tready  (q_tready[r]),
      .m_payload (q_beat[r])
    );

    // Split the head beat into arbiter lanes
    assign q_tdata[r] = q_beat[r].data;
    assign q_tkeep[r] = q_beat[r].keep;
    assign q_tlast[r] = q_beat[r].last;
  end

  // Per-beat round-robin merge
  axis_arbiter #(
    .N_ID       (N_REGIONS)
  ) u_arbiter (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .tready_snk (q_tready),
    .tvalid_snk (q_tvalid),
    .tdata_snk  (q_tdata),
    .tkeep_snk  (q_tkeep),
    .tlast_snk  (q_tlast),
    .tready_src (arb_tready),
    .tvalid_src (arb_tvalid),
    .tdata_src  (arb_tdata),
    .tkeep_src  (arb_tkeep),
    .tlast_src  (arb_tlast),
    .id_src     (arb_id)
  );

  // Tag the winning beat with its region
  assign arb_beat.beat.data = arb_tdata;
  assign arb_beat.beat.keep = arb_tkeep;
  assign arb_beat.beat.last = arb_tlast;
  assign arb_beat.id        = arb_id;

  // Output queue, decouples m_tready from the arbiter
  axis_fifo #(
    .payload_t (tagged_beat_t),
    .DEPTH     (OUT_DEPTH)
  ) u_out_fifo (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .s_tvalid  (arb_tvalid),
    .s_tready  (arb_tready),
    .s_payload (arb_beat),
    .m_tvalid  (m_tvalid),
    .m_tready  (m_tready),
    .m_payload (out_beat)
  );

  assign m_tdata = out_beat.beat.data;
  assign m_tkeep = out_beat.beat.keep;
  assign m_tlast = out_beat.beat.last;
  assign m_tid   = out_beat.id;          // Source region of this beat

endmodule

//--- sim/tb_stream_mux.sv
module tb_stream_mux;

  import stream_mux_pkg::*;

  // One row of the test table
  typedef struct packed {
    logic [N_REGIONS-1:0] mask;           // Regions that send
    int                   beats;          // Beats per enabled region
    logic                 lockstep;       // Enabled regions present each beat together
    int                   stall_pct;      // Share of cycles with m_tready low
    int                   hold;           // Opening cycles with m_tready held low
  } test_row_t;

  localparam int RST_CYCLES = 10;
  localparam int N_TESTS    = 6;

  localparam test_row_t TESTS [N_TESTS] = '{
    '{4'b0001,  9, 1'b0,  0,  0},         // Region 0 alone
    '{4'b1000,  9, 1'b0,  0,  0},         // Region 3 alone
    '{4'b1111,  4, 1'b1,  0,  0},         // Aligned start with 16 beats in turn
    '{4'b1111, 24, 1'b0, 30,  0},         // Gaps and random stalls
    '{4'b1111, 12, 1'b0,  0, 40},         // Long opening stall fills the queues
    '{4'b0101, 15, 1'b0, 50,  0}          // Two regions under heavy stalls
  };

  logic                                aclk;
  logic                                aresetn;
  logic [N_REGIONS-1:0]                s_tvalid;
  logic [N_REGIONS-1:0]                s_tready;
  logic [N_REGIONS-1:0][DATA_BITS-1:0] s_tdata;
  logic [N_REGIONS-1:0][KEEP_BITS-1:0] s_tkeep;
  logic [N_REGIONS-1:0]                s_tlast;
  logic                                m_tvalid;
  logic                                m_tready;
  logic [DATA_BITS-1:0]                m_tdata;
  logic [KEEP_BITS-1:0]                m_tkeep;
  logic                                m_tlast;
  logic [ID_BITS-1:0]                  m_tid;

  beat_t                sent_q [N_REGIONS][$]; // Accepted beats per region in arrival order
  int                   presented [N_REGIONS];
  logic [N_REGIONS-1:0] accepted;         // Taken at the coming edge
  logic [31:0]          rng;
  logic                 dropped;          // Some enabled s_tready seen low
  int                   cur_test;
  int                   n_sent;
  int                   n_out;
  int                   n_checks;
  int                   test_errs;
  int                   total_errs;

  stream_mux_top u_dut (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tdata  (s_tdata),
    .s_tkeep  (s_tkeep),
    .s_tlast  (s_tlast),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tdata  (m_tdata),
    .m_tkeep  (m_tkeep),
    .m_tlast  (m_tlast),
    .m_tid    (m_tid)
  );

  always #4 aclk = ~aclk;                 // Period 8

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_word();
    rng = xorshift32(rng);                // Advances the shared state
    return rng;
  endfunction

  function automatic string describe_row(input test_row_t row);
    if (row.hold > 0) return "back-pressure";
    if (row.lockstep) return "round-robin";
    if ($countones(row.mask) == 1) return "single region";
    return "mixed traffic";
  endfunction

  task automatic check_value(input string name, input logic [DATA_BITS-1:0] got,
                             input logic [DATA_BITS-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      $display("ERR t=%0t %s got %0h expected %0h", $time, name, got, exp);
      test_errs++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("test %0d at t=%0t: %s", cur_test, $time, what);
    test_errs++;
  endtask

  // Holds reset for RST_CYCLES rising edges and checks the idle state throughout
  task automatic apply_reset();
    int i;
    @(negedge aclk);
    aresetn  = 1'b0;
    s_tvalid = '0;
    m_tready = 1'b0;
    for (i = 1; i < RST_CYCLES; i++) begin
      @(negedge aclk);
      #2;
      check_value("m_tvalid", m_tvalid, 1'b0);
      check_value("s_tready", s_tready, {N_REGIONS{1'b1}});
    end
    @(negedge aclk);                      // Tenth reset edge has passed
    aresetn = 1'b1;
    @(negedge aclk);                      // First edge out of reset
    #2;
    check_value("m_tvalid", m_tvalid, 1'b0);
    check_value("s_tready", s_tready, {N_REGIONS{1'b1}});
  endtask

  task automatic present_beat(input int r);
    s_tdata[r]  = {rand_word(), rand_word()};
    s_tkeep[r]  = KEEP_BITS'(rand_word());
    s_tlast[r]  = (presented[r] % 3 == 2); // Packets of 3 beats
    s_tvalid[r] = 1'b1;
    presented[r]++;
  endtask

  // Drives on the falling edge and holds each beat until its transfer
  task automatic drive_inputs(input test_row_t row, input int cyc);
    int r;
    s_tvalid = s_tvalid & ~accepted;      // Drop beats taken at the last edge
    accepted = '0;
    if (row.lockstep) begin
      if ((s_tvalid & row.mask) == '0) begin
        for (r = 0; r < N_REGIONS; r++) begin
          if (row.mask[r] && presented[r] < row.beats) present_beat(r);
        end
      end
    end else begin
      for (r = 0; r < N_REGIONS; r++) begin
        if (row.mask[r] && !s_tvalid[r] && presented[r] < row.beats &&
            rand_word() % 4 != 0) begin   // About one gap in four
          present_beat(r);
        end
      end
    end
    if (cyc < row.hold) m_tready = 1'b0;
    else m_tready = (rand_word() % 100 >= row.stall_pct);
  endtask

  // Sampled mid low phase once the handshakes for the coming edge have settled
  task automatic sample_outputs(input test_row_t row);
    int    r;
    beat_t b;
    beat_t exp;
    for (r = 0; r < N_REGIONS; r++) begin
      if (s_tvalid[r] && s_tready[r]) begin
        b.data = s_tdata[r];
        b.keep = s_tkeep[r];
        b.last = s_tlast[r];
        sent_q[r].push_back(b);
        accepted[r] = 1'b1;
        n_sent++;
      end
      if (row.mask[r] && !s_tready[r]) dropped = 1'b1;
    end
    if (m_tvalid && m_tready) begin
      if (sent_q[m_tid].size() == 0) begin
        report_failure($sformatf("output beat on region %0d with nothing sent there", m_tid));
      end else begin
        exp = sent_q[m_tid].pop_front(); // Oldest beat of that region
        check_value("m_tdata", m_tdata, exp.data);
        check_value("m_tkeep", m_tkeep, exp.keep);
        check_value("m_tlast", m_tlast, exp.last);
      end
      if (row.lockstep && row.stall_pct == 0 && row.mask == '1) begin
        check_value("m_tid", m_tid, n_out % N_REGIONS); // Strict rotation from region 0
      end
      n_out++;
    end
  endtask

  task automatic run_test(input int idx);
    test_row_t row;
    int        total;
    int        cyc;
    int        r;
    row       = TESTS[idx];
    cur_test  = idx;
    test_errs = 0;
    n_sent    = 0;
    n_out     = 0;
    dropped   = 1'b0;
    accepted  = '0;
    for (r = 0; r < N_REGIONS; r++) begin
      presented[r] = 0;
      sent_q[r].delete();
    end
    apply_reset();                        // Pointer and queues aligned at start
    total = row.beats * $countones(row.mask);
    cyc   = 0;
    while (n_sent < total || n_out < total) begin
      @(negedge aclk);
      drive_inputs(row, cyc);
      #2;
      sample_outputs(row);
      cyc++;
    end
    repeat (4) begin                      // Idle tail where any extra beat would show
      @(negedge aclk);
      s_tvalid = '0;
      accepted = '0;
      m_tready = 1'b1;
      #2;
      sample_outputs(row);
    end
    check_value("beats out", n_out, n_sent);
    check_value("m_tvalid", m_tvalid, 1'b0);
    for (r = 0; r < N_REGIONS; r++) begin
      if (sent_q[r].size() != 0) begin
        report_failure($sformatf("%0d beats of region %0d never came out", sent_q[r].size(), r));
      end
    end
    if (row.hold > 0 && !dropped) begin
      report_failure("no s_tready went low while m_tready was held low");
    end
    $display("test %0d %s: %0d beats in, %0d out, %0d errors",
             idx, describe_row(row), n_sent, n_out, test_errs);
    total_errs += test_errs;
  endtask

  initial begin : main
    int t;
    aclk       = 1'b0;
    aresetn    = 1'b0;
    s_tvalid   = '0;
    s_tdata    = '0;
    s_tkeep    = '0;
    s_tlast    = '0;
    m_tready   = 1'b0;
    accepted   = '0;
    dropped    = 1'b0;
    rng        = 32'd2778;                // Fixed seed
    cur_test   = 0;
    n_sent     = 0;
    n_out      = 0;
    n_checks   = 0;
    test_errs  = 0;
    total_errs = 0;
    for (t = 0; t < N_TESTS; t++) begin
      run_test(t);
    end
    $display("%0d tests, %0d checks, %0d errors", N_TESTS, n_checks, total_errs);
    if (total_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Budget of 20 cycles per beat per region, plus reset, hold and drain time
  initial begin : watchdog
    int limit;
    int t;
    limit = 100;
    for (t = 0; t < N_TESTS; t++) begin
      limit = limit + TESTS[t].beats * N_REGIONS * 20 + TESTS[t].hold + RST_CYCLES + 20;
    end
    repeat (limit) @(posedge aclk);
    $display("Timeout after %0d cycles: test %0d (%s) hung with %0d beats in and %0d out",
             limit, cur_test, describe_row(TESTS[cur_test]), n_sent, n_out);
    $display("Checks failed");
    $finish;
  end

endmodule

//--- stream_mux.f
common/stream_mux_pkg.sv
hw/axis_fifo.sv
axis_arbiter/axis_arbiter.sv
hw/stream_mux_top.sv
sim/tb_stream_mux.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_stream_mux
FILELIST  := stream_mux.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Checks failed
PASS_MSG  := All checks passed

.PHONY: sim clean

# Build and run, then judge the run from its log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
